// File: source/dfp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths and counts for the front panel processor run control and
// panel scan logic. Every RTL block imports this package with a wildcard
////////////////////////////////////////////////////////////////////////////

package dfp_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // front panel data bus
   ////////////////////////////////////////////////////////////////////////////

   // the FPD bus carries one byte per slot
   localparam int fpd_width = 8;

   // 32 slots are scanned, which covers every light group on the panel
   localparam int scan_slots = 32;

   // enough address bits to name each of the 32 slots
   localparam int slot_width = 5;

   // all light bytes side by side, slot 0 in the lowest byte
   localparam int lights_width = scan_slots * fpd_width;

   ////////////////////////////////////////////////////////////////////////////
   // processor clock generation
   ////////////////////////////////////////////////////////////////////////////

   // speed select picks a divide ratio of 2 to the power speed_sel
   localparam int speed_width = 3;

   // the divider must reach 2**7 - 1 for the slowest speed
   localparam int div_width = (1 << speed_width) - 1;

   // every fourth processor clock enable ends a microstep
   localparam int phases_per_ustep = 4;

   // phase counter runs 0 to 3
   localparam int phase_width = 2;

endpackage : dfp_pkg

// File: source/dfp_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// processor clock enable generator. Divides clk4 by a power of two picked
// with speed_sel and flags each fourth enable as a microstep boundary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_clock_gen
   import dfp_pkg::*;
(
   input  logic                   clk4,
   input  logic                   rst_n,
   input  logic [speed_width-1:0] speed_sel,
   output logic                   fpclken_in,
   output logic                   fpustep_in
);

   // divider count, restarts at zero after each enable
   logic [div_width-1:0]   div_cnt;

   // terminal count of the divider for the speed now in use
   logic [div_width-1:0]   div_last;

   // speed in use, only updated when the divider wraps
   logic [speed_width-1:0] speed_q;

   // position of the current enable inside a microstep
   logic [phase_width-1:0] phase;

   logic                   div_wrap;
   logic                   phase_wrap;

   // 2**speed_q - 1, so speed 0 gives a terminal count of zero
   assign div_last = div_width'((32'd1 << speed_q) - 32'd1);

   assign div_wrap   = (div_cnt == div_last);
   assign phase_wrap = (phase == phase_width'(phases_per_ustep - 1));

   // one enable per divider period
   assign fpclken_in = div_wrap;

   // the boundary strobe rides on the enable that closes the microstep
   assign fpustep_in = div_wrap & phase_wrap;

   ////////////////////////////////////////////////////////////////////////////
   // divider
   ////////////////////////////////////////////////////////////////////////////

   // speed_q loads straight from the input during reset so the first
   // enable arrives one full period of the chosen speed later
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         div_cnt <= '0;
         speed_q <= speed_sel;
      end else if (div_wrap) begin
         div_cnt <= '0;
         // a new speed is only picked up here, never mid period
         speed_q <= speed_sel;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // microstep phase
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         phase <= '0;
      end else if (fpclken_in) begin
         if (phase_wrap)
            phase <= '0;
         else
            phase <= phase + 1'b1;
      end
   end

endmodule : dfp_clock_gen

// File: source/dfp_run_control.sv
////////////////////////////////////////////////////////////////////////////
// run control for the processor clock. Halts at instruction fetch, steps
// single instructions or microsteps and runs flat out during a reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_run_control (
   input  logic clk4,
   input  logic rst_n,
   input  logic step_nrun,
   input  logic fpfetch_nexec,
   input  logic nclr,
   input  logic nustep,
   input  logic nreset,
   input  logic nrsthold,
   input  logic fpclken_in,
   input  logic fpustep_in,
   output logic fpclken_out,
   output logic fpustep_out,
   output logic nwait
);

   // previous samples of the inputs whose edges matter
   logic fetch_q;
   logic nustep_q;
   logic nrsthold_q;

   // stepping means halted, ustepping grants one enable, resetting forces speed
   logic stepping;
   logic ustepping;
   logic resetting;
   logic stepping_d;
   logic ustepping_d;
   logic resetting_d;

   logic fetch_rise;
   logic nustep_fall;
   logic nrsthold_rise;
   logic halted;

   assign fetch_rise    = fpfetch_nexec & ~fetch_q;
   assign nustep_fall   = ~nustep & nustep_q;
   assign nrsthold_rise = nrsthold & ~nrsthold_q;

   ////////////////////////////////////////////////////////////////////////////
   // flag next state, nclr first then each flag by its own rules
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      stepping_d  = stepping;
      ustepping_d = ustepping;
      resetting_d = resetting;
      if (!nclr) begin
         stepping_d  = 1'b0;
         ustepping_d = 1'b0;
         resetting_d = 1'b0;
      end else begin
         // the end of the reset hold wins over a reset line still low
         if (nrsthold_rise)
            resetting_d = 1'b0;
         else if (!nreset)
            resetting_d = 1'b1;
         // run request releases the halt, a fetch edge in step mode sets it
         if (!step_nrun)
            stepping_d = 1'b0;
         else if (fetch_rise)
            stepping_d = 1'b1;
         // the granted enable is consumed on the edge where it passes
         if (ustepping && fpclken_in)
            ustepping_d = 1'b0;
         else if (nustep_fall && stepping)
            ustepping_d = 1'b1;
      end
   end

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         // edge detectors start at the idle level so reset makes no edge
         fetch_q    <= 1'b1;
         nustep_q   <= 1'b1;
         nrsthold_q <= 1'b1;
         stepping   <= 1'b0;
         ustepping  <= 1'b0;
         resetting  <= 1'b0;
         nwait      <= 1'b1;
      end else begin
         fetch_q    <= fpfetch_nexec;
         nustep_q   <= nustep;
         nrsthold_q <= nrsthold;
         stepping   <= stepping_d;
         ustepping  <= ustepping_d;
         resetting  <= resetting_d;
         // hold the MCU off while a halt is pending, a microstep runs or a reset runs
         nwait      <= ~((step_nrun & ~stepping_d) | ustepping_d | resetting_d);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // enable gating, same selection as the old '253 function table
   ////////////////////////////////////////////////////////////////////////////

   assign halted      = stepping & ~ustepping;
   assign fpclken_out = resetting | (fpclken_in & ~halted);
   assign fpustep_out = fpustep_in & (resetting | ~halted);

   // a halt that nothing releases must keep every enable blocked next cycle
   halt_blocks_clock : assert property (
      @(posedge clk4) disable iff (!rst_n)
      (halted && !resetting && nclr && step_nrun && nreset && !nustep_fall)
         |=> !fpclken_out
   );

endmodule : dfp_run_control

// File: source/dfp_scan_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// FPD slot scan. Walks the 32 slots one per cycle for the panel lights and
// lets the DFP steal single cycles to read a slot, answered two cycles later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_scan_sequencer
   import dfp_pkg::*;
(
   input  logic                  clk4,
   input  logic                  rst_n,
   input  logic                  rd_req,
   input  logic [slot_width-1:0] rd_slot,
   input  logic [fpd_width-1:0]  fpd_in,
   output logic [slot_width-1:0] slot_addr,
   output logic                  scan_strobe,
   output logic                  rd_valid,
   output logic [fpd_width-1:0]  rd_data
);

   // next slot the automatic scan will visit
   logic [slot_width-1:0] scan_cnt;

   // low for the first cycle out of reset so nothing is captured then
   logic                  scan_run;

   // a read owns the bus in this cycle
   logic                  rd_pend;
   logic [slot_width-1:0] rd_slot_q;

   ////////////////////////////////////////////////////////////////////////////
   // bus address
   ////////////////////////////////////////////////////////////////////////////

   // a pending read overrides the scan for exactly one cycle
   assign slot_addr   = rd_pend ? rd_slot_q : scan_cnt;

   // the latch only captures cycles that belong to the scan
   assign scan_strobe = scan_run & ~rd_pend;

   ////////////////////////////////////////////////////////////////////////////
   // scan counter
   ////////////////////////////////////////////////////////////////////////////

   // holding during a read keeps every slot in the rotation
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         scan_cnt <= '0;
         scan_run <= 1'b0;
      end else begin
         scan_run <= 1'b1;
         // 32 slots fill the counter so it wraps from 31 to 0 by itself
         if (scan_strobe)
            scan_cnt <= scan_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read pipeline
   ////////////////////////////////////////////////////////////////////////////

   // stage one drives the requested slot, stage two samples the bus
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         rd_pend  <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         rd_pend  <= rd_req;
         rd_valid <= rd_pend;
      end
   end

   // requested slot and its answer byte, qualified by rd_pend and rd_valid
   always_ff @(posedge clk4) begin
      if (rd_req)
         rd_slot_q <= rd_slot;
      if (rd_pend)
         rd_data <= fpd_in;
   end

   // every answer belongs to a request made exactly two edges before, and
   // the bus carried that requested slot in the cycle it was sampled
   read_answers_request : assert property (
      @(posedge clk4) disable iff (!rst_n)
      rd_valid |-> $past(rd_req, 2) && ($past(slot_addr) == $past(rd_slot, 2))
   );

   // the scan never drives its own slot while a read holds the bus
   read_stops_scan : assert property (
      @(posedge clk4) disable iff (!rst_n)
      rd_req |=> !scan_strobe && (slot_addr == $past(rd_slot))
   );

endmodule : dfp_scan_sequencer

// File: source/dfp_light_latch.sv
////////////////////////////////////////////////////////////////////////////
// panel light store. Keeps the last byte seen on the FPD bus for each of
// the 32 slots and presents them as one flat vector to the panel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_light_latch
   import dfp_pkg::*;
(
   input  logic                    clk4,
   input  logic                    rst_n,
   input  logic [slot_width-1:0]   slot_addr,
   input  logic                    scan_strobe,
   input  logic [fpd_width-1:0]    fpd_in,
   output logic [lights_width-1:0] panel_lights
);

   // one byte per slot
   logic [fpd_width-1:0] lights [scan_slots];

   ////////////////////////////////////////////////////////////////////////////
   // capture
   ////////////////////////////////////////////////////////////////////////////

   // lights go dark on reset until the scan has filled them in
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         for (int i = 0; i < scan_slots; i++) begin
            lights[i] <= '0;
         end
      end else if (scan_strobe) begin
         // the DFP read cycles never land here, so their data is not shown
         lights[slot_addr] <= fpd_in;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // flat output
   ////////////////////////////////////////////////////////////////////////////

   // slot n occupies bits n*8 up to n*8+7
   always_comb begin
      for (int i = 0; i < scan_slots; i++) begin
         panel_lights[i*fpd_width +: fpd_width] = lights[i];
      end
   end

endmodule : dfp_light_latch

// File: source/dfp_top.sv
////////////////////////////////////////////////////////////////////////////
// DFP run control and panel scan top level. Sits between the computer's
// clock and FPD bus and the DFP microcontroller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_top
   import dfp_pkg::*;
(
   input  logic                    clk4,
   input  logic                    rst_n,

   // clock and run controls from the DFP microcontroller
   input  logic [speed_width-1:0]  speed_sel,
   input  logic                    step_nrun,
   input  logic                    nclr,
   input  logic                    nustep,

   // state and reset lines from the computer
   input  logic                    fpfetch_nexec,
   input  logic                    nreset,
   input  logic                    nrsthold,

   // FPD bus and the DFP read port
   input  logic [fpd_width-1:0]    fpd_in,
   input  logic                    rd_req,
   input  logic [slot_width-1:0]   rd_slot,

   output logic                    fpclken_out,
   output logic                    fpustep_out,
   output logic                    nwait,
   output logic [slot_width-1:0]   slot_addr,
   output logic                    rd_valid,
   output logic [fpd_width-1:0]    rd_data,
   output logic [lights_width-1:0] panel_lights
);

   // free running enables before the run control gates them
   logic fpclken_in;
   logic fpustep_in;

   // marks the scan cycles the light latch may capture
   logic scan_strobe;

   ////////////////////////////////////////////////////////////////////////////
   // processor clock path
   ////////////////////////////////////////////////////////////////////////////

   dfp_clock_gen u_clock_gen (
      .clk4       (clk4),
      .rst_n      (rst_n),
      .speed_sel  (speed_sel),
      .fpclken_in (fpclken_in),
      .fpustep_in (fpustep_in)
   );

   dfp_run_control u_run_control (
      .clk4          (clk4),
      .rst_n         (rst_n),
      .step_nrun     (step_nrun),
      .fpfetch_nexec (fpfetch_nexec),
      .nclr          (nclr),
      .nustep        (nustep),
      .nreset        (nreset),
      .nrsthold      (nrsthold),
      .fpclken_in    (fpclken_in),
      .fpustep_in    (fpustep_in),
      .fpclken_out   (fpclken_out),
      .fpustep_out   (fpustep_out),
      .nwait         (nwait)
   );

   ////////////////////////////////////////////////////////////////////////////
   // FPD scan path
   ////////////////////////////////////////////////////////////////////////////

   dfp_scan_sequencer u_scan_sequencer (
      .clk4        (clk4),
      .rst_n       (rst_n),
      .rd_req      (rd_req),
      .rd_slot     (rd_slot),
      .fpd_in      (fpd_in),
      .slot_addr   (slot_addr),
      .scan_strobe (scan_strobe),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data)
   );

   // the latch watches the same slot address the computer is given
   dfp_light_latch u_light_latch (
      .clk4         (clk4),
      .rst_n        (rst_n),
      .slot_addr    (slot_addr),
      .scan_strobe  (scan_strobe),
      .fpd_in       (fpd_in),
      .panel_lights (panel_lights)
   );

endmodule : dfp_top

// File: test/dfp_tb_clk.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset source. clk4 runs at 20 ns and rst_n is held
// low over the first three rising edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_tb_clk (
   output logic clk4,
   output logic rst_n
);

   initial begin
      clk4 = 1'b0;
      forever #10 clk4 = ~clk4;
   end

   // release lands 2 ns after an edge, like every other driven input
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk4);
      #2 rst_n = 1'b1;
   end

endmodule : dfp_tb_clk

// File: test/dfp_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the DFP run control and panel scan. Models the
// computer's FPD bus and checks clock gating, halts, microsteps and reads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dfp_tb
   import dfp_pkg::*;
();

   // the tests need about 750 cycles, so this leaves a wide margin
   localparam int cycle_limit = 3000;

   logic                    clk4;
   logic                    rst_n;
   logic [speed_width-1:0]  speed_sel;
   logic                    step_nrun;
   logic                    fpfetch_nexec;
   logic                    nclr;
   logic                    nustep;
   logic                    nreset;
   logic                    nrsthold;
   logic [fpd_width-1:0]    fpd_in;
   logic                    rd_req;
   logic [slot_width-1:0]   rd_slot;
   logic                    fpclken_out;
   logic                    fpustep_out;
   logic                    nwait;
   logic [slot_width-1:0]   slot_addr;
   logic                    rd_valid;
   logic [fpd_width-1:0]    rd_data;
   logic [lights_width-1:0] panel_lights;

   // state byte of the modelled computer, mixed into every slot value
   logic [fpd_width-1:0]    bus_state;
   int                      cycle_count;

   dfp_tb_clk u_clk (
      .clk4  (clk4),
      .rst_n (rst_n)
   );

   dfp_top DUT (
      .clk4          (clk4),
      .rst_n         (rst_n),
      .speed_sel     (speed_sel),
      .step_nrun     (step_nrun),
      .nclr          (nclr),
      .nustep        (nustep),
      .fpfetch_nexec (fpfetch_nexec),
      .nreset        (nreset),
      .nrsthold      (nrsthold),
      .fpd_in        (fpd_in),
      .rd_req        (rd_req),
      .rd_slot       (rd_slot),
      .fpclken_out   (fpclken_out),
      .fpustep_out   (fpustep_out),
      .nwait         (nwait),
      .slot_addr     (slot_addr),
      .rd_valid      (rd_valid),
      .rd_data       (rd_data),
      .panel_lights  (panel_lights)
   );

   ////////////////////////////////////////////////////////////////////////////
   // computer model and expected values
   ////////////////////////////////////////////////////////////////////////////

   // every slot gets a distinct byte since the slot fills the top five bits
   function automatic logic [fpd_width-1:0] slot_byte(
      input logic [slot_width-1:0] slot,
      input logic [fpd_width-1:0]  state
   );
      logic [fpd_width-1:0] mix;
      mix = {slot, slot[2:0]} + 8'h3b;
      return mix ^ state;
   endfunction

   // the computer answers whatever slot is on the address lines
   assign fpd_in = slot_byte(slot_addr, bus_state);

   // slot n is expected in bits n*8 up to n*8+7 of the panel vector
   function automatic logic [lights_width-1:0] expected_lights(
      input logic [fpd_width-1:0] state
   );
      logic [lights_width-1:0] v;
      for (int i = 0; i < scan_slots; i++) begin
         v[i*fpd_width +: fpd_width] = slot_byte(slot_width'(i), state);
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // reporting and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
                            $time, name, got, exp));
   endtask

   task automatic compare_byte(input string name, input logic [fpd_width-1:0] got,
                               input logic [fpd_width-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   task automatic compare_slot(input string name, input logic [slot_width-1:0] got,
                               input logic [slot_width-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                            $time, name, got, exp));
   endtask

   task automatic compare_lights(input string name, input logic [lights_width-1:0] got,
                                 input logic [lights_width-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   task automatic compare_count(input string name, input int got, input int exp);
      if (got != exp)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                            $time, name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // cycle helpers
   ////////////////////////////////////////////////////////////////////////////

   // lands 2 ns after the rising edge, where inputs change and outputs are read
   task automatic next_cycle();
      @(posedge clk4);
      #2;
   endtask

   task automatic count_pulses(input int cycles, output int clk_pulses,
                               output int ustep_pulses);
      clk_pulses   = 0;
      ustep_pulses = 0;
      repeat (cycles) begin
         next_cycle();
         if (fpclken_out === 1'b1)
            clk_pulses++;
         if (fpustep_out === 1'b1)
            ustep_pulses++;
      end
   endtask

   task automatic wait_nwait(input logic level, input int limit, input string when);
      int n;
      n = 0;
      while (nwait !== level && n < limit) begin
         next_cycle();
         n++;
      end
      if (nwait !== level)
         fail_run($sformatf("nwait did not reach %b within %0d cycles %s",
                            level, limit, when));
   endtask

   // a halted processor sees no enable and the microcontroller is free
   task automatic hold_halted(input int cycles);
      repeat (cycles) begin
         next_cycle();
         compare_bit("fpclken_out", fpclken_out, 1'b0);
         compare_bit("nwait", nwait, 1'b1);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_after_reset();
      compare_bit("nwait", nwait, 1'b1);
      compare_bit("rd_valid", rd_valid, 1'b0);
      compare_slot("slot_addr", slot_addr, '0);
   endtask

   // any 64 cycles hold exactly 64 / 2**speed enables, a quarter of them ustep
   task automatic test_clock_speed();
      int clk_pulses;
      int ustep_pulses;
      for (int s = 0; s < 4; s++) begin
         speed_sel = speed_width'(s);
         repeat (16) next_cycle();
         count_pulses(64, clk_pulses, ustep_pulses);
         compare_count("fpclken_out pulses", clk_pulses, 64 >> s);
         compare_count("fpustep_out pulses", ustep_pulses, 16 >> s);
      end
      // the rest of the run uses one enable every two cycles
      speed_sel = speed_width'(1);
      repeat (16) next_cycle();
   endtask

   task automatic test_halt_and_step();
      int clk_pulses;
      int ustep_pulses;
      step_nrun = 1'b1;
      next_cycle();
      // the halt is requested but no fetch edge has come yet
      compare_bit("nwait", nwait, 1'b0);
      repeat (3) next_cycle();
      fpfetch_nexec = 1'b1;
      wait_nwait(1'b1, 4, "after the fetch edge");
      hold_halted(100);
      fpfetch_nexec = 1'b0;
      next_cycle();
      // one instruction step is a single cycle of step_nrun low
      step_nrun = 1'b0;
      next_cycle();
      step_nrun = 1'b1;
      count_pulses(4, clk_pulses, ustep_pulses);
      compare_count("fpclken_out pulses while stepping", clk_pulses, 2);
      compare_bit("nwait", nwait, 1'b0);
      fpfetch_nexec = 1'b1;
      wait_nwait(1'b1, 4, "after the second fetch edge");
      hold_halted(100);
      fpfetch_nexec = 1'b0;
   endtask

   task automatic test_microstep();
      int waited;
      nustep = 1'b0;
      waited = 0;
      // nwait stays low up to and including the cycle of the granted enable
      do begin
         next_cycle();
         nustep = 1'b1;
         waited++;
         compare_bit("nwait", nwait, 1'b0);
      end while (fpclken_out !== 1'b1 && waited < 8);
      if (fpclken_out !== 1'b1)
         fail_run("no clock enable passed after the microstep request");
      hold_halted(20);
   endtask

   task automatic test_reset_speed();
      int clk_pulses;
      int ustep_pulses;
      nreset   = 1'b0;
      nrsthold = 1'b0;
      ustep_pulses = 0;
      // full speed during reset, ustep still at one per 8 cycles of speed 1
      repeat (16) begin
         next_cycle();
         compare_bit("fpclken_out", fpclken_out, 1'b1);
         compare_bit("nwait", nwait, 1'b0);
         if (fpustep_out === 1'b1)
            ustep_pulses++;
      end
      compare_count("fpustep_out pulses in reset", ustep_pulses, 2);
      nreset   = 1'b1;
      nrsthold = 1'b1;
      // the halt from before the reset is still in force
      hold_halted(20);
      nclr = 1'b0;
      next_cycle();
      nclr = 1'b1;
      count_pulses(4, clk_pulses, ustep_pulses);
      compare_count("fpclken_out pulses after clear", clk_pulses, 2);
      compare_bit("nwait", nwait, 1'b0);
      step_nrun = 1'b0;
      next_cycle();
      compare_bit("nwait", nwait, 1'b1);
   endtask

   task automatic test_scan_and_read();
      logic [slot_width-1:0] slots [20];
      bus_state = 8'ha6;
      repeat (40) next_cycle();
      compare_lights("panel_lights", panel_lights, expected_lights(bus_state));
      for (int n = 0; n < 20; n++) begin
         slots[n] = slot_width'($urandom % scan_slots);
      end
      // a request made in loop pass n drives the bus in pass n+1 and is
      // answered in pass n+2
      for (int n = 0; n < 23; n++) begin
         if (n >= 1 && n < 21)
            compare_slot("slot_addr", slot_addr, slots[n-1]);
         if (n >= 2 && n < 22) begin
            compare_bit("rd_valid", rd_valid, 1'b1);
            compare_byte("rd_data", rd_data, slot_byte(slots[n-2], bus_state));
         end else begin
            compare_bit("rd_valid", rd_valid, 1'b0);
         end
         if (n < 20) begin
            rd_req  = 1'b1;
            rd_slot = slots[n];
         end else begin
            rd_req  = 1'b0;
         end
         next_cycle();
      end
      // a new computer state must reach every light within one full scan
      bus_state = 8'h5c;
      repeat (scan_slots) next_cycle();
      compare_lights("panel_lights", panel_lights, expected_lights(bus_state));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk4);
         cycle_count++;
         if (cycle_count > cycle_limit)
            fail_run($sformatf("timeout, run still busy after %0d cycles", cycle_limit));
      end
   end

   initial begin
      void'($urandom(32'hc34f_5df4));
      speed_sel     = '0;
      step_nrun     = 1'b0;
      fpfetch_nexec = 1'b0;
      nclr          = 1'b1;
      nustep        = 1'b1;
      nreset        = 1'b1;
      nrsthold      = 1'b1;
      rd_req        = 1'b0;
      rd_slot       = '0;
      bus_state     = 8'h00;
      wait (rst_n === 1'b1);
      check_after_reset();
      test_clock_speed();
      test_halt_and_step();
      test_microstep();
      test_reset_speed();
      test_scan_and_read();
      $display("TEST PASS");
      $finish;
   end

endmodule : dfp_tb

// File: src.f
source/dfp_pkg.sv
source/dfp_clock_gen.sv
source/dfp_run_control.sv
source/dfp_scan_sequencer.sv
source/dfp_light_latch.sv
source/dfp_top.sv
test/dfp_tb_clk.sv
test/dfp_tb.sv

// File: Bender.yml
package:
  name: dfp_run_scan

sources:
  - files:
      - source/dfp_pkg.sv
      - source/dfp_clock_gen.sv
      - source/dfp_run_control.sv
      - source/dfp_scan_sequencer.sv
      - source/dfp_light_latch.sv
      - source/dfp_top.sv
  - target: test
    files:
      - test/dfp_tb_clk.sv
      - test/dfp_tb.sv
